//--- project.f
src/decode_pkg.sv
src/inst_decoder.sv
src/stage_register.sv
src/decode_stage.sv
test/decode_stage_properties.sv
test/tb_decode_stage.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_decode_stage
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/tb_decode_stage.sv
`timescale 1ns/100ps

module tb_decode_stage import decode_pkg::*; ();

	localparam int n_bundles = 400;
	// Back-to-back phase before lock and flush start toggling
	localparam int warmup_bundles = 100;
	localparam int timeout_cycles = n_bundles * 8 + 50;
	localparam int drain_cycles = 4;

	logic clock;
	logic reset;
	logic flush;
	logic prev_common_valid;
	logic next_lock;
	logic prev_lock;
	logic next_common_valid;
	logic [data_width-1:0] prev_pc;
	logic [data_width-1:0] next_pc;

	// Fetch side per slot
	logic prev_0_inst_valid, prev_0_pagefault, prev_0_paging_ena;
	logic prev_0_kernel_access, prev_0_branch_predict;
	logic [data_width-1:0] prev_0_branch_predict_addr, prev_0_inst;
	logic prev_1_inst_valid, prev_1_pagefault, prev_1_paging_ena;
	logic prev_1_kernel_access, prev_1_branch_predict;
	logic [data_width-1:0] prev_1_branch_predict_addr, prev_1_inst;

	// Decoded side of slot 0
	logic next_0_valid, next_0_fault_pagefault, next_0_fault_invalid_inst;
	logic next_0_paging_ena, next_0_kernel_access, next_0_branch_predict;
	logic next_0_source0_active, next_0_source1_active, next_0_source1_imm;
	logic next_0_writeback, next_0_flags_writeback;
	logic next_0_ex_logic, next_0_ex_shift, next_0_ex_adder;
	logic next_0_ex_mul, next_0_ex_ldst, next_0_ex_branch;
	logic [cmd_width-1:0] next_0_cmd;
	logic [cc_width-1:0] next_0_cc;
	logic [reg_index_width-1:0] next_0_source0, next_0_destination;
	logic [data_width-1:0] next_0_branch_predict_addr, next_0_source1;

	// Decoded side of slot 1
	logic next_1_valid, next_1_fault_pagefault, next_1_fault_invalid_inst;
	logic next_1_paging_ena, next_1_kernel_access, next_1_branch_predict;
	logic next_1_source0_active, next_1_source1_active, next_1_source1_imm;
	logic next_1_writeback, next_1_flags_writeback;
	logic next_1_ex_logic, next_1_ex_shift, next_1_ex_adder;
	logic next_1_ex_mul, next_1_ex_ldst, next_1_ex_branch;
	logic [cmd_width-1:0] next_1_cmd;
	logic [cc_width-1:0] next_1_cc;
	logic [reg_index_width-1:0] next_1_source0, next_1_destination;
	logic [data_width-1:0] next_1_branch_predict_addr, next_1_source1;

	logic [15:0] lfsr_state;
	int cycle;
	int accepted;
	int drained;
	logic took_last;
	logic was_reset;
	// Expected outputs with one entry per accepted bundle
	logic [105:0] passthru_q[$];
	logic [62:0] slot0_q[$];
	logic [62:0] slot1_q[$];

	decode_stage dut0 (.*);

	always #10 clock = ~clock;

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One LFSR step per returned bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	// Reference decode in the field order of slot_outputs
	function automatic logic [62:0] decode_model(input logic [31:0] w);
		logic [5:0] op;
		logic [2:0] unit;
		logic is_imm;
		logic ok;
		logic store;
		logic [31:0] operand;
		logic [3:0] cond;
		logic [5:0] sel;
		op = w[31:26];
		unit = op[4:2];
		is_imm = op[5];
		ok = unit <= unit_branch;
		store = unit == unit_ldst && op[0];
		// One-hot with the logic unit at the top bit
		sel = ok ? (6'b100000 >> unit) : 6'b000000;
		operand = is_imm ? {{16{w[15]}}, w[15:0]} : {27'b0, w[15:11]};
		cond = is_imm ? 4'b0000 : w[10:7];
		return {!ok, ok, ok && !is_imm, ok && is_imm,
			ok && unit != unit_branch && !store,
			ok && (unit == unit_logic || unit == unit_adder),
			op[4:0], cond, w[20:16], w[25:21], operand, sel};
	endfunction

	function automatic logic [105:0] passthru_outputs();
		return {next_0_valid, next_1_valid,
			next_0_fault_pagefault, next_0_paging_ena, next_0_kernel_access,
			next_0_branch_predict, next_0_branch_predict_addr,
			next_1_fault_pagefault, next_1_paging_ena, next_1_kernel_access,
			next_1_branch_predict, next_1_branch_predict_addr, next_pc};
	endfunction

	function automatic logic [62:0] slot_outputs(input int slot);
		if (slot == 0)
			return {next_0_fault_invalid_inst, next_0_source0_active, next_0_source1_active,
				next_0_source1_imm, next_0_writeback, next_0_flags_writeback, next_0_cmd,
				next_0_cc, next_0_source0, next_0_destination, next_0_source1,
				next_0_ex_logic, next_0_ex_shift, next_0_ex_adder, next_0_ex_mul,
				next_0_ex_ldst, next_0_ex_branch};
		return {next_1_fault_invalid_inst, next_1_source0_active, next_1_source1_active,
			next_1_source1_imm, next_1_writeback, next_1_flags_writeback, next_1_cmd,
			next_1_cc, next_1_source0, next_1_destination, next_1_source1,
			next_1_ex_logic, next_1_ex_shift, next_1_ex_adder, next_1_ex_mul,
			next_1_ex_ldst, next_1_ex_branch};
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic compare_value(input logic [127:0] actual, input logic [127:0] expected,
		input string what);
		if (actual !== expected)
			stop_with_failure($sformatf("FAIL time %0t: %s expected %h got %h",
				$time, what, expected, actual));
	endtask

	initial begin
		clock = 1'b0;
		lfsr_state = 16'd29864;
		cycle = 0;
		accepted = 0;
		drained = 0;
		took_last = 1'b0;
		was_reset = 1'b0;
		reset <= 1'b1;
		flush <= 1'b0;
		prev_common_valid <= 1'b0;
		next_lock <= 1'b0;
		prev_pc <= '0;
		prev_0_inst_valid <= 1'b0;
		prev_0_pagefault <= 1'b0;
		prev_0_paging_ena <= 1'b0;
		prev_0_kernel_access <= 1'b0;
		prev_0_branch_predict <= 1'b0;
		prev_0_branch_predict_addr <= '0;
		prev_0_inst <= '0;
		prev_1_inst_valid <= 1'b0;
		prev_1_pagefault <= 1'b0;
		prev_1_paging_ena <= 1'b0;
		prev_1_kernel_access <= 1'b0;
		prev_1_branch_predict <= 1'b0;
		prev_1_branch_predict_addr <= '0;
		prev_1_inst <= '0;
	end

	always @(posedge clock) begin
		cycle = cycle + 1;
		// Score with the values held just before this edge
		if (reset) begin
			was_reset = 1'b1;
			took_last = 1'b0;
		end else begin
			if (was_reset) begin
				compare_value(128'({next_common_valid, next_0_valid, next_1_valid, prev_lock}),
					128'(0), "outputs after reset");
				was_reset = 1'b0;
			end
			// Locked only while the model holds a bundle that the next stage refuses
			compare_value(128'(prev_lock), 128'(passthru_q.size() != 0 && next_lock),
				"prev_lock");
			if (took_last)
				compare_value(128'(next_common_valid), 128'(1), "bundle one cycle after take");
			if (flush) begin
				compare_value(128'({next_0_valid, next_1_valid}), 128'(0), "valids in flush");
				// Held bundle and any take on this edge are dropped
				passthru_q.delete();
				slot0_q.delete();
				slot1_q.delete();
				took_last = 1'b0;
			end else begin
				if (next_common_valid && !next_lock) begin
					if (passthru_q.size() == 0) begin
						stop_with_failure($sformatf(
							"FAIL time %0t: bundle delivered that was never accepted", $time));
					end else begin
						compare_value(128'(passthru_outputs()), 128'(passthru_q.pop_front()),
							"pass-through fields");
						compare_value(128'(slot_outputs(0)), 128'(slot0_q.pop_front()),
							"slot 0 decode");
						compare_value(128'(slot_outputs(1)), 128'(slot1_q.pop_front()),
							"slot 1 decode");
					end
				end
				took_last = prev_common_valid && !prev_lock;
				if (took_last) begin
					passthru_q.push_back({prev_0_inst_valid, prev_1_inst_valid,
						prev_0_pagefault, prev_0_paging_ena, prev_0_kernel_access,
						prev_0_branch_predict, prev_0_branch_predict_addr,
						prev_1_pagefault, prev_1_paging_ena, prev_1_kernel_access,
						prev_1_branch_predict, prev_1_branch_predict_addr, prev_pc});
					slot0_q.push_back(decode_model(prev_0_inst));
					slot1_q.push_back(decode_model(prev_1_inst));
					accepted = accepted + 1;
				end
			end
		end

		// Stimulus for the next edge
		if (cycle == 3)
			reset <= 1'b0;
		if (cycle < 3 || accepted >= n_bundles) begin
			prev_common_valid <= 1'b0;
			next_lock <= 1'b0;
			flush <= 1'b0;
			if (accepted >= n_bundles)
				drained = drained + 1;
		end else if (accepted < warmup_bundles) begin
			prev_common_valid <= 1'b1;
			next_lock <= 1'b0;
			flush <= 1'b0;
		end else begin
			prev_common_valid <= rand_bits(2) != 0;
			next_lock <= rand_bits(2) == 3;
			flush <= rand_bits(6) == 0;
		end
		prev_pc <= rand_bits(32);
		prev_0_inst_valid <= rand_bits(3) != 0;
		prev_0_pagefault <= rand_bits(1) == 1;
		prev_0_paging_ena <= rand_bits(1) == 1;
		prev_0_kernel_access <= rand_bits(1) == 1;
		prev_0_branch_predict <= rand_bits(1) == 1;
		prev_0_branch_predict_addr <= rand_bits(32);
		prev_0_inst <= rand_bits(32);
		prev_1_inst_valid <= rand_bits(3) != 0;
		prev_1_pagefault <= rand_bits(1) == 1;
		prev_1_paging_ena <= rand_bits(1) == 1;
		prev_1_kernel_access <= rand_bits(1) == 1;
		prev_1_branch_predict <= rand_bits(1) == 1;
		prev_1_branch_predict_addr <= rand_bits(32);
		prev_1_inst <= rand_bits(32);

		// Every accepted bundle must have left by now
		if (drained > drain_cycles) begin
			if (passthru_q.size() == 0) begin
				$display("SIMULATION PASSED");
				$finish;
			end else begin
				stop_with_failure($sformatf("%0d accepted bundles never left the decode stage",
					passthru_q.size()));
			end
		end else if (cycle >= timeout_cycles) begin
			stop_with_failure($sformatf("Timeout: only %0d of %0d bundles accepted in %0d cycles",
				accepted, n_bundles, cycle));
		end
	end

endmodule

//--- test/decode_stage_properties.sv
`timescale 1ns/100ps

module decode_stage_properties import decode_pkg::*; (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic prev_lock,
	input logic next_lock,
	input logic next_common_valid,
	input logic next_0_valid,
	input logic next_1_valid,
	input logic [data_width-1:0] next_pc,
	input logic [data_width-1:0] next_0_source1,
	input logic [data_width-1:0] next_1_source1,
	input logic [cmd_width-1:0] next_0_cmd,
	input logic [cmd_width-1:0] next_1_cmd
);

	// A refused bundle stays put until the next stage takes it or a flush drops it
	hold_stable: assert property (@(posedge clock) disable iff (reset)
		next_common_valid && next_lock && !flush |=> next_common_valid && $stable(next_pc)
			&& $stable(next_0_source1) && $stable(next_1_source1)
			&& $stable(next_0_cmd) && $stable(next_1_cmd))
		else $error("bundle changed while next_lock was high");

	// Sync reset empties everything
	reset_empty: assert property (@(posedge clock)
		reset |=> !next_common_valid && !next_0_valid && !next_1_valid && !prev_lock)
		else $error("stage not empty after reset");

	slot_needs_bundle: assert property (@(posedge clock) disable iff (reset)
		next_0_valid || next_1_valid |-> next_common_valid)
		else $error("slot valid without next_common_valid");

endmodule

bind decode_stage decode_stage_properties props0 (
	.clock(clock), .reset(reset), .flush(flush), .prev_lock(prev_lock),
	.next_lock(next_lock), .next_common_valid(next_common_valid),
	.next_0_valid(next_0_valid), .next_1_valid(next_1_valid), .next_pc(next_pc),
	.next_0_source1(next_0_source1), .next_1_source1(next_1_source1),
	.next_0_cmd(next_0_cmd), .next_1_cmd(next_1_cmd)
);

//--- src/decode_stage.sv
`timescale 1ns/100ps

module decode_stage import decode_pkg::*; (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic prev_common_valid,
	input logic prev_0_inst_valid,
	input logic prev_0_pagefault,
	input logic prev_0_paging_ena,
	input logic prev_0_kernel_access,
	input logic prev_0_branch_predict,
	input logic [data_width-1:0] prev_0_branch_predict_addr,
	input logic [data_width-1:0] prev_0_inst,
	input logic prev_1_inst_valid,
	input logic prev_1_pagefault,
	input logic prev_1_paging_ena,
	input logic prev_1_kernel_access,
	input logic prev_1_branch_predict,
	input logic [data_width-1:0] prev_1_branch_predict_addr,
	input logic [data_width-1:0] prev_1_inst,
	input logic [data_width-1:0] prev_pc,
	output logic prev_lock,
	output logic next_common_valid,
	output logic next_0_valid,
	output logic next_0_fault_pagefault,
	output logic next_0_fault_invalid_inst,
	output logic next_0_paging_ena,
	output logic next_0_kernel_access,
	output logic next_0_branch_predict,
	output logic [data_width-1:0] next_0_branch_predict_addr,
	output logic next_0_source0_active,
	output logic next_0_source1_active,
	output logic next_0_source1_imm,
	output logic next_0_writeback,
	output logic next_0_flags_writeback,
	output logic [cmd_width-1:0] next_0_cmd,
	output logic [cc_width-1:0] next_0_cc,
	output logic [reg_index_width-1:0] next_0_source0,
	output logic [reg_index_width-1:0] next_0_destination,
	output logic [data_width-1:0] next_0_source1,
	output logic next_0_ex_logic,
	output logic next_0_ex_shift,
	output logic next_0_ex_adder,
	output logic next_0_ex_mul,
	output logic next_0_ex_ldst,
	output logic next_0_ex_branch,
	output logic next_1_valid,
	output logic next_1_fault_pagefault,
	output logic next_1_fault_invalid_inst,
	output logic next_1_paging_ena,
	output logic next_1_kernel_access,
	output logic next_1_branch_predict,
	output logic [data_width-1:0] next_1_branch_predict_addr,
	output logic next_1_source0_active,
	output logic next_1_source1_active,
	output logic next_1_source1_imm,
	output logic next_1_writeback,
	output logic next_1_flags_writeback,
	output logic [cmd_width-1:0] next_1_cmd,
	output logic [cc_width-1:0] next_1_cc,
	output logic [reg_index_width-1:0] next_1_source0,
	output logic [reg_index_width-1:0] next_1_destination,
	output logic [data_width-1:0] next_1_source1,
	output logic next_1_ex_logic,
	output logic next_1_ex_shift,
	output logic next_1_ex_adder,
	output logic next_1_ex_mul,
	output logic next_1_ex_ldst,
	output logic next_1_ex_branch,
	output logic [data_width-1:0] next_pc,
	input logic next_lock
);

	// Per slot: pagefault, paging, kernel, predict and the predicted address
	localparam int sys_slot_width = 4 + data_width;
	localparam int sys_width = 2 * sys_slot_width + data_width;
	// Slot valid, six flags, cmd, cc, two indices, operand, six unit selects
	localparam int pipe_width = 7 + cmd_width + cc_width + 2 * reg_index_width + data_width + 6;

	logic sys_busy;
	logic pipe0_busy;
	logic pipe1_busy;
	logic pipe0_req;
	logic pipe1_req;
	logic pipe0_valid;
	logic pipe1_valid;
	logic take;

	// Decoder results, flags msb first: invalid, src0, src1, imm, wb, flags wb
	logic [5:0] dec0_flag;
	logic [5:0] dec1_flag;
	// Unit selects msb first: logic, shift, adder, mul, ldst, branch
	logic [5:0] dec0_ex;
	logic [5:0] dec1_ex;
	logic [cmd_width-1:0] dec0_cmd;
	logic [cmd_width-1:0] dec1_cmd;
	logic [cc_width-1:0] dec0_cc;
	logic [cc_width-1:0] dec1_cc;
	logic [reg_index_width-1:0] dec0_src0;
	logic [reg_index_width-1:0] dec1_src0;
	logic [reg_index_width-1:0] dec0_dest;
	logic [reg_index_width-1:0] dec1_dest;
	logic [data_width-1:0] dec0_src1;
	logic [data_width-1:0] dec1_src1;

	// All three registers move together, any one stalling locks fetch
	assign prev_lock = sys_busy || pipe0_busy || pipe1_busy;
	assign take = prev_common_valid && !prev_lock;

	inst_decoder decode0 (
		.inst(prev_0_inst),
		.fault_invalid_inst(dec0_flag[5]), .source0_active(dec0_flag[4]),
		.source1_active(dec0_flag[3]), .source1_imm(dec0_flag[2]),
		.writeback(dec0_flag[1]), .flags_writeback(dec0_flag[0]),
		.cmd(dec0_cmd), .cc(dec0_cc), .source0(dec0_src0),
		.destination(dec0_dest), .source1(dec0_src1),
		.ex_logic(dec0_ex[5]), .ex_shift(dec0_ex[4]), .ex_adder(dec0_ex[3]),
		.ex_mul(dec0_ex[2]), .ex_ldst(dec0_ex[1]), .ex_branch(dec0_ex[0])
	);

	inst_decoder decode1 (
		.inst(prev_1_inst),
		.fault_invalid_inst(dec1_flag[5]), .source0_active(dec1_flag[4]),
		.source1_active(dec1_flag[3]), .source1_imm(dec1_flag[2]),
		.writeback(dec1_flag[1]), .flags_writeback(dec1_flag[0]),
		.cmd(dec1_cmd), .cc(dec1_cc), .source0(dec1_src0),
		.destination(dec1_dest), .source1(dec1_src1),
		.ex_logic(dec1_ex[5]), .ex_shift(dec1_ex[4]), .ex_adder(dec1_ex[3]),
		.ex_mul(dec1_ex[2]), .ex_ldst(dec1_ex[1]), .ex_branch(dec1_ex[0])
	);

	// Fetch side info and PC, passed through untouched
	stage_register #(.WIDTH(sys_width)) stage_system (
		.clock(clock), .reset(reset), .flush(flush),
		.prev_req(take), .prev_busy(sys_busy),
		.prev_data({prev_0_pagefault, prev_0_paging_ena, prev_0_kernel_access,
			prev_0_branch_predict, prev_0_branch_predict_addr,
			prev_1_pagefault, prev_1_paging_ena, prev_1_kernel_access,
			prev_1_branch_predict, prev_1_branch_predict_addr, prev_pc}),
		.next_req(next_common_valid), .next_busy(next_lock),
		.next_data({next_0_fault_pagefault, next_0_paging_ena, next_0_kernel_access,
			next_0_branch_predict, next_0_branch_predict_addr,
			next_1_fault_pagefault, next_1_paging_ena, next_1_kernel_access,
			next_1_branch_predict, next_1_branch_predict_addr, next_pc})
	);

	stage_register #(.WIDTH(pipe_width)) stage_pipe0 (
		.clock(clock), .reset(reset), .flush(flush),
		.prev_req(take), .prev_busy(pipe0_busy),
		.prev_data({prev_0_inst_valid, dec0_flag, dec0_cmd, dec0_cc, dec0_src0,
			dec0_dest, dec0_src1, dec0_ex}),
		.next_req(pipe0_req), .next_busy(next_lock),
		.next_data({pipe0_valid, next_0_fault_invalid_inst, next_0_source0_active,
			next_0_source1_active, next_0_source1_imm, next_0_writeback,
			next_0_flags_writeback, next_0_cmd, next_0_cc, next_0_source0,
			next_0_destination, next_0_source1, next_0_ex_logic, next_0_ex_shift,
			next_0_ex_adder, next_0_ex_mul, next_0_ex_ldst, next_0_ex_branch})
	);

	stage_register #(.WIDTH(pipe_width)) stage_pipe1 (
		.clock(clock), .reset(reset), .flush(flush),
		.prev_req(take), .prev_busy(pipe1_busy),
		.prev_data({prev_1_inst_valid, dec1_flag, dec1_cmd, dec1_cc, dec1_src0,
			dec1_dest, dec1_src1, dec1_ex}),
		.next_req(pipe1_req), .next_busy(next_lock),
		.next_data({pipe1_valid, next_1_fault_invalid_inst, next_1_source0_active,
			next_1_source1_active, next_1_source1_imm, next_1_writeback,
			next_1_flags_writeback, next_1_cmd, next_1_cc, next_1_source0,
			next_1_destination, next_1_source1, next_1_ex_logic, next_1_ex_shift,
			next_1_ex_adder, next_1_ex_mul, next_1_ex_ldst, next_1_ex_branch})
	);

	// Stale valid bits in an empty register never leak, flush kills them at once
	assign next_0_valid = pipe0_req && pipe0_valid && !flush;
	assign next_1_valid = pipe1_req && pipe1_valid && !flush;

endmodule

//--- src/stage_register.sv
`timescale 1ns/100ps

module stage_register #(
	parameter int WIDTH = 32
) (
	input logic clock,
	input logic reset,
	input logic flush,
	input logic prev_req,
	input logic next_busy,
	input logic [WIDTH-1:0] prev_data,
	output logic prev_busy,
	output logic next_req,
	output logic [WIDTH-1:0] next_data
);

	logic full;
	logic load;

	// Stall upstream only when holding a bundle the next stage refuses
	assign prev_busy = full && next_busy;
	assign load = prev_req && !prev_busy;
	assign next_req = full;

	// Occupancy, flush wins over a load on the same edge
	always_ff @(posedge clock) begin
		if (reset || flush) begin
			full <= 1'b0;
		end else if (load) begin
			full <= 1'b1;
		end else if (!next_busy) begin
			// Drained with nothing new behind it
			full <= 1'b0;
		end
	end

	// Payload
	always_ff @(posedge clock) begin
		if (load) begin
			next_data <= prev_data;
		end
	end

endmodule

//--- src/inst_decoder.sv
`timescale 1ns/100ps

module inst_decoder import decode_pkg::*; (
	input inst_word_t inst,
	output logic fault_invalid_inst,
	output logic source0_active,
	output logic source1_active,
	output logic source1_imm,
	output logic writeback,
	output logic flags_writeback,
	output logic [cmd_width-1:0] cmd,
	output logic [cc_width-1:0] cc,
	output logic [reg_index_width-1:0] source0,
	output logic [reg_index_width-1:0] destination,
	output logic [data_width-1:0] source1,
	output logic ex_logic,
	output logic ex_shift,
	output logic ex_adder,
	output logic ex_mul,
	output logic ex_ldst,
	output logic ex_branch
);

	logic [unit_width-1:0] unit;
	logic imm_form;
	logic is_store;
	logic valid;

	// Opcode sits at the top in both views
	assign unit = inst.reg_form.opcode[op_unit_msb:op_unit_lsb];
	assign imm_form = inst.reg_form.opcode[op_imm_bit];

	// One-hot unit select
	always_comb begin
		ex_logic = 1'b0;
		ex_shift = 1'b0;
		ex_adder = 1'b0;
		ex_mul = 1'b0;
		ex_ldst = 1'b0;
		ex_branch = 1'b0;
		valid = 1'b1;
		case (unit)
			unit_logic: ex_logic = 1'b1;
			unit_shift: ex_shift = 1'b1;
			unit_adder: ex_adder = 1'b1;
			unit_mul: ex_mul = 1'b1;
			unit_ldst: ex_ldst = 1'b1;
			unit_branch: ex_branch = 1'b1;
			// Codes 6 and 7, no unit
			default: valid = 1'b0;
		endcase
	end

	assign fault_invalid_inst = !valid;

	// Store is an ldst with the low opcode bit set
	assign is_store = ex_ldst && inst.reg_form.opcode[op_store_bit];

	// Raw fields
	assign cmd = inst.reg_form.opcode[cmd_width-1:0];
	assign source0 = inst.reg_form.src0;
	assign destination = inst.reg_form.dest;

	// Second operand and condition code by form
	always_comb begin
		if (imm_form) begin
			// Sign-extended immediate, no condition
			source1 = {{(data_width-imm_width){inst.imm_form.imm[imm_width-1]}},
				inst.imm_form.imm};
			cc = '0;
		end else begin
			// Register index, zero-extended
			source1 = {{(data_width-reg_index_width){1'b0}}, inst.reg_form.src1};
			cc = inst.reg_form.cc;
		end
	end

	// Operand usage, all cleared for an invalid word
	assign source0_active = valid;
	assign source1_active = valid && !imm_form;
	assign source1_imm = valid && imm_form;

	// No register result from branches and stores
	assign writeback = valid && !ex_branch && !is_store;
	// Flags come from logic and adder only
	assign flags_writeback = ex_logic || ex_adder;

endmodule

//--- src/decode_pkg.sv
package decode_pkg;

	// Datapath widths
	localparam int data_width = 32;
	localparam int reg_index_width = 5;
	localparam int cmd_width = 5;
	localparam int cc_width = 4;
	localparam int opcode_width = 6;
	localparam int imm_width = 16;
	localparam int unit_width = 3;
	// Leftover bits at the bottom of a register-form word
	localparam int reserved_width = data_width - opcode_width - 3 * reg_index_width - cc_width;

	// Execution unit codes, 6 and 7 are undefined
	localparam logic [unit_width-1:0] unit_logic = 3'd0;
	localparam logic [unit_width-1:0] unit_shift = 3'd1;
	localparam logic [unit_width-1:0] unit_adder = 3'd2;
	localparam logic [unit_width-1:0] unit_mul = 3'd3;
	localparam logic [unit_width-1:0] unit_ldst = 3'd4;
	localparam logic [unit_width-1:0] unit_branch = 3'd5;

	// Opcode bit positions
	localparam int op_imm_bit = 5;
	localparam int op_unit_msb = 4;
	localparam int op_unit_lsb = 2;
	// Only meaningful inside the ldst unit
	localparam int op_store_bit = 0;

	// Same 32 bits, read as register form or immediate form
	typedef union packed {
		struct packed {
			logic [opcode_width-1:0] opcode;
			logic [reg_index_width-1:0] dest;
			logic [reg_index_width-1:0] src0;
			logic [reg_index_width-1:0] src1;
			logic [cc_width-1:0] cc;
			logic [reserved_width-1:0] reserved;
		} reg_form;
		struct packed {
			logic [opcode_width-1:0] opcode;
			logic [reg_index_width-1:0] dest;
			logic [reg_index_width-1:0] src0;
			logic [imm_width-1:0] imm;
		} imm_form;
	} inst_word_t;

endpackage
